// File: regfile_pkg.sv
// ====================
// Register file shared types and sizes
// ====================

package regfile_pkg;

	// Physical register count of the core
	localparam int PREGS = 64;

	// Width of a physical register number, enough to name all PREGS entries
	localparam int PREG_BITS = 6;

	// Width of a register value
	localparam int VALUE_BITS = 64;

	// Four writeback buses feed the file, one per named write port
	localparam int WRITE_PORTS = 4;

	// A bank selector names one of the write ports
	localparam int LVT_BITS = 2;

	// ====================
	// Types
	// ====================

	// Physical register number
	typedef logic [PREG_BITS-1:0] pregno_t;

	// Register value as seen on the writeback and operand buses
	typedef logic [VALUE_BITS-1:0] value_t;

	// Live value table entry, the write port that last wrote a register
	typedef logic [LVT_BITS-1:0] lvt_sel_t;

endpackage

// File: regfile_bank_ram.sv
`timescale 1ns/1ps

// One bank of the register file
// A bank is a small distributed RAM with a single write port and a single
// asynchronous read port, so one bank exists per write port and read port pair
module regfile_bank_ram (
	input  logic                 clk,
	input  logic                 we,
	input  regfile_pkg::pregno_t waddr,
	input  regfile_pkg::value_t  wdata,
	input  regfile_pkg::pregno_t raddr,
	output regfile_pkg::value_t  rdata
);

	// ====================
	// Storage
	// ====================

	// One entry per physical register
	// Contents come up undefined and are only valid after a write
	regfile_pkg::value_t mem [regfile_pkg::PREGS];

	// ====================
	// Write port
	// ====================

	// The write lands at the clock edge, so a read of the same address in the
	// same cycle still returns the old contents
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// ====================
	// Read port
	// ====================

	// Asynchronous read, data follows the address within the cycle
	// The multiport wrapper relies on this to keep operand fetch combinational
	assign rdata = mem[raddr];

endmodule

// File: regfile_lvt.sv
`timescale 1ns/1ps

// Live value table
// For every physical register it keeps the number of the write port whose
// bank holds the newest copy, and it looks that number up for each read port
module regfile_lvt #(
	parameter int READ_PORTS = 4
) (
	input  logic                                    clk,
	input  logic                                    rst,
	input  logic                                    we0,
	input  logic                                    we1,
	input  logic                                    we2,
	input  logic                                    we3,
	input  regfile_pkg::pregno_t                    wa0,
	input  regfile_pkg::pregno_t                    wa1,
	input  regfile_pkg::pregno_t                    wa2,
	input  regfile_pkg::pregno_t                    wa3,
	input  regfile_pkg::pregno_t  [READ_PORTS-1:0]  ra,
	output regfile_pkg::lvt_sel_t [READ_PORTS-1:0]  sel
);

	// One selector per physical register
	regfile_pkg::lvt_sel_t table_q [regfile_pkg::PREGS];

	// ====================
	// Update
	// ====================

	// Reset points every register at bank 0
	// The ports are applied in ascending order, so when two ports hit the same
	// register the later statement, and thus the higher port, wins
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < regfile_pkg::PREGS; i++) begin
				table_q[i] <= '0;
			end
		end else begin
			if (we0) table_q[wa0] <= regfile_pkg::lvt_sel_t'(0);
			if (we1) table_q[wa1] <= regfile_pkg::lvt_sel_t'(1);
			if (we2) table_q[wa2] <= regfile_pkg::lvt_sel_t'(2);
			if (we3) table_q[wa3] <= regfile_pkg::lvt_sel_t'(3);
		end
	end

	// ====================
	// Lookup
	// ====================

	// Combinational lookup for every read port
	always_comb begin
		for (int r = 0; r < READ_PORTS; r++) begin
			sel[r] = table_q[ra[r]];
		end
	end

endmodule

// File: regfile_multiport.sv
`timescale 1ns/1ps

// Banked multiport register file
// Each write port owns a group of banks, one bank per read port, and every
// bank in a group takes the same write. The live value table picks which
// group holds the newest copy of the register a read port asks for
module regfile_multiport #(
	parameter int READ_PORTS = 4
) (
	input  logic                                   clk,
	input  logic                                   rst,
	input  logic                                   we0,
	input  logic                                   we1,
	input  logic                                   we2,
	input  logic                                   we3,
	input  regfile_pkg::pregno_t                   wa0,
	input  regfile_pkg::pregno_t                   wa1,
	input  regfile_pkg::pregno_t                   wa2,
	input  regfile_pkg::pregno_t                   wa3,
	input  regfile_pkg::value_t                    wd0,
	input  regfile_pkg::value_t                    wd1,
	input  regfile_pkg::value_t                    wd2,
	input  regfile_pkg::value_t                    wd3,
	input  regfile_pkg::pregno_t [READ_PORTS-1:0]  ra,
	output regfile_pkg::value_t  [READ_PORTS-1:0]  rd
);

	// ====================
	// Write port gathering
	// ====================

	// The four named write ports collected into arrays so that the bank
	// groups and the bypass can be generated by write port index
	logic                 we_v [regfile_pkg::WRITE_PORTS];
	regfile_pkg::pregno_t wa_v [regfile_pkg::WRITE_PORTS];
	regfile_pkg::value_t  wd_v [regfile_pkg::WRITE_PORTS];

	assign we_v[0] = we0;
	assign we_v[1] = we1;
	assign we_v[2] = we2;
	assign we_v[3] = we3;

	assign wa_v[0] = wa0;
	assign wa_v[1] = wa1;
	assign wa_v[2] = wa2;
	assign wa_v[3] = wa3;

	assign wd_v[0] = wd0;
	assign wd_v[1] = wd1;
	assign wd_v[2] = wd2;
	assign wd_v[3] = wd3;

	// ====================
	// Banks
	// ====================

	// Bank outputs indexed by write port, then by read port
	regfile_pkg::value_t [READ_PORTS-1:0] bank_q [regfile_pkg::WRITE_PORTS];

	for (genvar w = 0; w < regfile_pkg::WRITE_PORTS; w++) begin : g_wport
		for (genvar r = 0; r < READ_PORTS; r++) begin : g_rport
			regfile_bank_ram u_bank (
				.clk   (clk),
				.we    (we_v[w]),
				.waddr (wa_v[w]),
				.wdata (wd_v[w]),
				.raddr (ra[r]),
				.rdata (bank_q[w][r])
			);
		end
	end

	// ====================
	// Live value table
	// ====================

	// Bank selector for every read port
	regfile_pkg::lvt_sel_t [READ_PORTS-1:0] sel;

	regfile_lvt #(
		.READ_PORTS (READ_PORTS)
	) u_lvt (
		.clk (clk),
		.rst (rst),
		.we0 (we0),
		.we1 (we1),
		.we2 (we2),
		.we3 (we3),
		.wa0 (wa0),
		.wa1 (wa1),
		.wa2 (wa2),
		.wa3 (wa3),
		.ra  (ra),
		.sel (sel)
	);

	// ====================
	// Read selection
	// ====================

	// Start from the bank the live value table names
	// A write to the same address in this cycle has not reached the banks yet,
	// so it is bypassed. The loop runs upward and the highest port wins
	// Register 0 is forced to zero last, whatever the banks hold
	always_comb begin
		for (int r = 0; r < READ_PORTS; r++) begin
			rd[r] = bank_q[sel[r]][r];
			for (int w = 0; w < regfile_pkg::WRITE_PORTS; w++) begin
				if (we_v[w] && (wa_v[w] == ra[r])) begin
					rd[r] = wd_v[w];
				end
			end
			if (ra[r] == '0) begin
				rd[r] = '0;
			end
		end
	end

endmodule

// File: regfile_write_stage.sv
`timescale 1ns/1ps

// Writeback staging register
// The four writeback buses are registered here before they reach the banks.
// A write aimed at register 0 loses its enable, so register 0 is never stored
module regfile_write_stage (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 wr_en0,
	input  logic                 wr_en1,
	input  logic                 wr_en2,
	input  logic                 wr_en3,
	input  regfile_pkg::pregno_t wr_addr0,
	input  regfile_pkg::pregno_t wr_addr1,
	input  regfile_pkg::pregno_t wr_addr2,
	input  regfile_pkg::pregno_t wr_addr3,
	input  regfile_pkg::value_t  wr_data0,
	input  regfile_pkg::value_t  wr_data1,
	input  regfile_pkg::value_t  wr_data2,
	input  regfile_pkg::value_t  wr_data3,
	output logic                 st_en0,
	output logic                 st_en1,
	output logic                 st_en2,
	output logic                 st_en3,
	output regfile_pkg::pregno_t st_addr0,
	output regfile_pkg::pregno_t st_addr1,
	output regfile_pkg::pregno_t st_addr2,
	output regfile_pkg::pregno_t st_addr3,
	output regfile_pkg::value_t  st_data0,
	output regfile_pkg::value_t  st_data1,
	output regfile_pkg::value_t  st_data2,
	output regfile_pkg::value_t  st_data3
);

	// ====================
	// Enables
	// ====================

	// Staged enables clear at reset
	// Writes to register 0 are dropped here, once, for all banks
	always_ff @(posedge clk) begin
		if (rst) begin
			st_en0 <= 1'b0;
			st_en1 <= 1'b0;
			st_en2 <= 1'b0;
			st_en3 <= 1'b0;
		end else begin
			st_en0 <= wr_en0 && (wr_addr0 != '0);
			st_en1 <= wr_en1 && (wr_addr1 != '0);
			st_en2 <= wr_en2 && (wr_addr2 != '0);
			st_en3 <= wr_en3 && (wr_addr3 != '0);
		end
	end

	// ====================
	// Payload
	// ====================

	// Address and data are only looked at when the staged enable is high
	always_ff @(posedge clk) begin
		st_addr0 <= wr_addr0;
		st_addr1 <= wr_addr1;
		st_addr2 <= wr_addr2;
		st_addr3 <= wr_addr3;
		st_data0 <= wr_data0;
		st_data1 <= wr_data1;
		st_data2 <= wr_data2;
		st_data3 <= wr_data3;
	end

endmodule

// File: regfile_read_stage.sv
`timescale 1ns/1ps

// Operand latch
// Each read port's combinational result is captured at the edge that ends
// the read cycle, and a valid flag travels alongside it
module regfile_read_stage #(
	parameter int READ_PORTS = 4
) (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                [READ_PORTS-1:0]  rd_en,
	input  regfile_pkg::value_t [READ_PORTS-1:0]  comb_data,
	output regfile_pkg::value_t [READ_PORTS-1:0]  rd_data,
	output logic                [READ_PORTS-1:0]  rd_valid
);

	// ====================
	// Valid flags
	// ====================

	// One cycle after a read strobe the result is marked valid
	// A port that was idle shows a low valid in the next cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_valid <= '0;
		end else begin
			rd_valid <= rd_en;
		end
	end

	// ====================
	// Data capture
	// ====================

	// Data is held while the port is idle, so the last operand stays on
	// the bus until the next read of that port
	always_ff @(posedge clk) begin
		for (int r = 0; r < READ_PORTS; r++) begin
			if (rd_en[r]) begin
				rd_data[r] <= comb_data[r];
			end
		end
	end

endmodule

// File: regfile_top.sv
`timescale 1ns/1ps

// Register file subsystem
// Writeback buses enter through the staging register, operand reads go
// straight into the multiport file and leave through the operand latch.
// Total read latency is one cycle, and a write is visible to reads from the
// cycle after it is presented
module regfile_top #(
	parameter int READ_PORTS = 4
) (
	input  logic                                   clk,
	input  logic                                   rst,
	input  logic                                   wr_en0,
	input  logic                                   wr_en1,
	input  logic                                   wr_en2,
	input  logic                                   wr_en3,
	input  regfile_pkg::pregno_t                   wr_addr0,
	input  regfile_pkg::pregno_t                   wr_addr1,
	input  regfile_pkg::pregno_t                   wr_addr2,
	input  regfile_pkg::pregno_t                   wr_addr3,
	input  regfile_pkg::value_t                    wr_data0,
	input  regfile_pkg::value_t                    wr_data1,
	input  regfile_pkg::value_t                    wr_data2,
	input  regfile_pkg::value_t                    wr_data3,
	input  logic                 [READ_PORTS-1:0]  rd_en,
	input  regfile_pkg::pregno_t [READ_PORTS-1:0]  rd_addr,
	output regfile_pkg::value_t  [READ_PORTS-1:0]  rd_data,
	output logic                 [READ_PORTS-1:0]  rd_valid
);

	// ====================
	// Staged writes
	// ====================

	logic                 st_en0;
	logic                 st_en1;
	logic                 st_en2;
	logic                 st_en3;
	regfile_pkg::pregno_t st_addr0;
	regfile_pkg::pregno_t st_addr1;
	regfile_pkg::pregno_t st_addr2;
	regfile_pkg::pregno_t st_addr3;
	regfile_pkg::value_t  st_data0;
	regfile_pkg::value_t  st_data1;
	regfile_pkg::value_t  st_data2;
	regfile_pkg::value_t  st_data3;

	regfile_write_stage u_write_stage (
		.clk      (clk),
		.rst      (rst),
		.wr_en0   (wr_en0),
		.wr_en1   (wr_en1),
		.wr_en2   (wr_en2),
		.wr_en3   (wr_en3),
		.wr_addr0 (wr_addr0),
		.wr_addr1 (wr_addr1),
		.wr_addr2 (wr_addr2),
		.wr_addr3 (wr_addr3),
		.wr_data0 (wr_data0),
		.wr_data1 (wr_data1),
		.wr_data2 (wr_data2),
		.wr_data3 (wr_data3),
		.st_en0   (st_en0),
		.st_en1   (st_en1),
		.st_en2   (st_en2),
		.st_en3   (st_en3),
		.st_addr0 (st_addr0),
		.st_addr1 (st_addr1),
		.st_addr2 (st_addr2),
		.st_addr3 (st_addr3),
		.st_data0 (st_data0),
		.st_data1 (st_data1),
		.st_data2 (st_data2),
		.st_data3 (st_data3)
	);

	// ====================
	// Register file core
	// ====================

	// Combinational read results, one per read port
	regfile_pkg::value_t [READ_PORTS-1:0] comb_data;

	regfile_multiport #(
		.READ_PORTS (READ_PORTS)
	) u_multiport (
		.clk (clk),
		.rst (rst),
		.we0 (st_en0),
		.we1 (st_en1),
		.we2 (st_en2),
		.we3 (st_en3),
		.wa0 (st_addr0),
		.wa1 (st_addr1),
		.wa2 (st_addr2),
		.wa3 (st_addr3),
		.wd0 (st_data0),
		.wd1 (st_data1),
		.wd2 (st_data2),
		.wd3 (st_data3),
		.ra  (rd_addr),
		.rd  (comb_data)
	);

	// ====================
	// Operand latch
	// ====================

	regfile_read_stage #(
		.READ_PORTS (READ_PORTS)
	) u_read_stage (
		.clk       (clk),
		.rst       (rst),
		.rd_en     (rd_en),
		.comb_data (comb_data),
		.rd_data   (rd_data),
		.rd_valid  (rd_valid)
	);

endmodule

// File: regfile_tb.sv
`timescale 1ns/1ps

module regfile_tb;

	// ====================
	// Sizes and signals
	// ====================

	localparam int READ_PORTS = 4;
	localparam int MAX_STEPS = 300;
	localparam int RANDOM_STEPS = 200;
	localparam int RESET_TIMEOUT = 20;

	logic                                   clk;
	logic                                   rst;
	logic                                   wr_en0, wr_en1, wr_en2, wr_en3;
	regfile_pkg::pregno_t                   wr_addr0, wr_addr1, wr_addr2, wr_addr3;
	regfile_pkg::value_t                    wr_data0, wr_data1, wr_data2, wr_data3;
	logic                 [READ_PORTS-1:0]  rd_en;
	regfile_pkg::pregno_t [READ_PORTS-1:0]  rd_addr;
	regfile_pkg::value_t  [READ_PORTS-1:0]  rd_data;
	logic                 [READ_PORTS-1:0]  rd_valid;

	// Stimulus table, one row per cycle, with the expected read data per port
	logic [3:0]           s_wen   [MAX_STEPS];
	regfile_pkg::pregno_t s_waddr [MAX_STEPS][4];
	regfile_pkg::value_t  s_wdata [MAX_STEPS][4];
	bit                   s_wrand [MAX_STEPS][4];
	logic [3:0]           s_ren   [MAX_STEPS];
	regfile_pkg::pregno_t s_raddr [MAX_STEPS][4];
	regfile_pkg::value_t  s_exp   [MAX_STEPS][4];
	int                   n_steps = 0;

	regfile_top #(
		.READ_PORTS (READ_PORTS)
	) u_dut (
		.clk      (clk),
		.rst      (rst),
		.wr_en0   (wr_en0),
		.wr_en1   (wr_en1),
		.wr_en2   (wr_en2),
		.wr_en3   (wr_en3),
		.wr_addr0 (wr_addr0),
		.wr_addr1 (wr_addr1),
		.wr_addr2 (wr_addr2),
		.wr_addr3 (wr_addr3),
		.wr_data0 (wr_data0),
		.wr_data1 (wr_data1),
		.wr_data2 (wr_data2),
		.wr_data3 (wr_data3),
		.rd_en    (rd_en),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data),
		.rd_valid (rd_valid)
	);

	// 10 ns clock
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Reset held for four rising edges, released just after the fourth
	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clk);
		#1 rst = 1'b0;
	end

	// ====================
	// Table building
	// ====================

	// Appends an idle row, later calls fill in its ports
	task automatic new_step();
		s_wen[n_steps] = '0;
		s_ren[n_steps] = '0;
		for (int p = 0; p < 4; p++) begin
			s_waddr[n_steps][p] = '0;
			s_wdata[n_steps][p] = '0;
			s_wrand[n_steps][p] = 1'b0;
			s_raddr[n_steps][p] = '0;
			s_exp[n_steps][p] = '0;
		end
		n_steps++;
	endtask

	// A set rnd flag marks the data field to be drawn from $urandom later
	task automatic set_write(input int p, input int addr, input regfile_pkg::value_t data,
			input bit rnd);
		s_wen[n_steps-1][p] = 1'b1;
		s_waddr[n_steps-1][p] = regfile_pkg::pregno_t'(addr);
		s_wdata[n_steps-1][p] = data;
		s_wrand[n_steps-1][p] = rnd;
	endtask

	task automatic set_read(input int p, input int addr);
		s_ren[n_steps-1][p] = 1'b1;
		s_raddr[n_steps-1][p] = regfile_pkg::pregno_t'(addr);
	endtask

	// Reference model pass over the table
	// A read sees every write of earlier rows and none of its own row, and
	// within a row the ports apply in ascending order so port 3 ends on top
	task automatic compute_expected();
		regfile_pkg::value_t model [regfile_pkg::PREGS];
		for (int i = 0; i < regfile_pkg::PREGS; i++) begin
			model[i] = '0;
		end
		for (int s = 0; s < n_steps; s++) begin
			for (int p = 0; p < 4; p++) begin
				if (s_wrand[s][p]) s_wdata[s][p] = {$urandom, $urandom};
				if (s_ren[s][p]) begin
					s_exp[s][p] = (s_raddr[s][p] == 0) ? '0 : model[s_raddr[s][p]];
				end
			end
			for (int p = 0; p < 4; p++) begin
				if (s_wen[s][p] && s_waddr[s][p] != 0) model[s_waddr[s][p]] = s_wdata[s][p];
			end
		end
	endtask

	// ====================
	// Driving and checking
	// ====================

	// Rows past the end of the table drive an idle bus
	task automatic drive_step(input int s);
		logic [3:0] wen;
		logic [3:0] ren;
		wen = (s < n_steps) ? s_wen[s] : 4'b0;
		ren = (s < n_steps) ? s_ren[s] : 4'b0;
		wr_en0 = wen[0];
		wr_en1 = wen[1];
		wr_en2 = wen[2];
		wr_en3 = wen[3];
		if (s < n_steps) begin
			wr_addr0 = s_waddr[s][0];
			wr_addr1 = s_waddr[s][1];
			wr_addr2 = s_waddr[s][2];
			wr_addr3 = s_waddr[s][3];
			wr_data0 = s_wdata[s][0];
			wr_data1 = s_wdata[s][1];
			wr_data2 = s_wdata[s][2];
			wr_data3 = s_wdata[s][3];
			for (int p = 0; p < READ_PORTS; p++) rd_addr[p] = s_raddr[s][p];
		end
		rd_en = ren;
	endtask

	task automatic report_mismatch(input string sig, input int p, input int s,
			input regfile_pkg::value_t exp_v, input regfile_pkg::value_t act_v);
		$display("Error: %s[%0d] for step %0d expected %h actual %h", sig, p, s, exp_v, act_v);
		$display("TB FAILED");
		$fatal(1, "Stopping at the first mismatch");
	endtask

	// Outputs during the cycle after row s belong to row s
	task automatic check_step(input int s);
		for (int p = 0; p < READ_PORTS; p++) begin
			assert (rd_valid[p] === s_ren[s][p])
			else report_mismatch("rd_valid", p, s, 64'(s_ren[s][p]), 64'(rd_valid[p]));
			if (s_ren[s][p]) begin
				assert (rd_data[p] === s_exp[s][p])
				else report_mismatch("rd_data", p, s, s_exp[s][p], rd_data[p]);
			end
		end
	endtask

	// ====================
	// Main sequence
	// ====================

	initial begin
		int unsigned seed_val;
		int wait_cycles;
		seed_val = $urandom(14648);
		drive_step(MAX_STEPS);
		wr_addr0 = '0;
		wr_addr1 = '0;
		wr_addr2 = '0;
		wr_addr3 = '0;
		wr_data0 = '0;
		wr_data1 = '0;
		wr_data2 = '0;
		wr_data3 = '0;
		rd_addr = '0;

		// Quiet rows straight after reset, nothing may turn valid
		new_step();
		new_step();
		// Fill 1..63 with ports taking turns, then read everything back
		for (int i = 1; i < regfile_pkg::PREGS; i++) begin
			if ((i - 1) % 4 == 0) new_step();
			set_write((i - 1) % 4, i, '0, 1'b1);
		end
		for (int i = 1; i < regfile_pkg::PREGS; i++) begin
			if ((i - 1) % 4 == 0) new_step();
			set_read((i - 1) % 4, i);
		end
		// Register 0 ignores a write with nonzero data
		new_step();
		set_write(2, 0, 64'hdead_beef_0000_0001, 1'b0);
		set_read(0, 0);
		new_step();
		for (int p = 0; p < 4; p++) set_read(p, 0);
		new_step();
		set_read(3, 0);
		// All ports on register 10, then ports 0 and 2 on register 11
		new_step();
		for (int p = 0; p < 4; p++) set_write(p, 10, 64'h1000_0000_0000_0000 + p, 1'b0);
		new_step();
		set_write(0, 11, 64'h0b00_0000_0000_00a0, 1'b0);
		set_write(2, 11, 64'h0b00_0000_0000_00a2, 1'b0);
		set_read(0, 10);
		new_step();
		set_read(1, 10);
		set_read(2, 11);
		// Same row sees the old value, the next row gets it through the bypass
		new_step();
		set_write(1, 20, 64'h2020_2020_5a5a_5a5a, 1'b0);
		set_read(0, 20);
		new_step();
		set_read(1, 20);
		set_read(3, 20);
		new_step();
		set_read(2, 20);
		// Random traffic on every port
		for (int i = 0; i < RANDOM_STEPS; i++) begin
			new_step();
			for (int p = 0; p < 4; p++) begin
				if ($urandom % 2) set_write(p, $urandom % regfile_pkg::PREGS, '0, 1'b1);
				if ($urandom % 2) set_read(p, $urandom % regfile_pkg::PREGS);
			end
		end
		compute_expected();

		// An unknown reset level counts as still in reset
		wait_cycles = 0;
		while (rst !== 1'b0) begin
			@(posedge clk);
			wait_cycles++;
			if (wait_cycles > RESET_TIMEOUT) begin
				$display("Reset never went low");
				$display("TB FAILED");
				$fatal(1, "Reset timeout");
			end
		end
		#1;
		assert (rd_valid === '0)
		else report_mismatch("rd_valid", 0, -1, '0, 64'(rd_valid));

		// One row per cycle, each row checked in the cycle after it
		for (int s = 0; s <= n_steps; s++) begin
			@(posedge clk);
			#1;
			if (s > 0) check_step(s - 1);
			drive_step(s);
		end
		$display("TB PASSED");
		$finish;
	end

endmodule

// File: src.f
regfile_pkg.sv
regfile_bank_ram.sv
regfile_lvt.sv
regfile_multiport.sv
regfile_write_stage.sv
regfile_read_stage.sv
regfile_top.sv
regfile_tb.sv

// File: Bender.yml
package:
  name: regfile

sources:
  - files:
      - regfile_pkg.sv
      - regfile_bank_ram.sv
      - regfile_lvt.sv
      - regfile_multiport.sv
      - regfile_write_stage.sv
      - regfile_read_stage.sv
      - regfile_top.sv
  - target: test
    files:
      - regfile_tb.sv
